// ==== build.f ====
hdl/aoi_pkg.sv
hdl/aoi_frame_ctrl.sv
hdl/aoi_window_gen.sv
hdl/aoi_stat_out.sv
hdl/wb_aoi_sel.sv
testbench/tb_clk_gen.sv
testbench/tb_wb_aoi_sel.sv

// ==== testbench/tb_wb_aoi_sel.sv ====
`timescale 1ns/100ps

module tb_wb_aoi_sel;

	// ----------------------------------------------------------
	// run shape
	// ----------------------------------------------------------
	localparam int RST_CYCLES  = 8;
	localparam int FRAMES      = 6;
	localparam int LINES       = 6;
	localparam int BEATS       = 16;
	localparam int GAP_CYC     = 3;
	localparam int END_GAP     = 8;
	localparam int MID_LINE    = 2;
	localparam int TAIL_CYC    = 6;
	localparam int DRV_DLY     = 2;
	localparam int FRAME_CYC   = 3 + GAP_CYC + LINES * (BEATS + GAP_CYC) + END_GAP;
	localparam int STIM_CYC    = RST_CYCLES + FRAMES * FRAME_CYC + TAIL_CYC;
	localparam int TIMEOUT_CYC = 2 * STIM_CYC;
	localparam logic [31:0] LFSR_SEED = 32'hd213_e2cc;

	logic clk;
	logic rst_n;
	logic i_fval;
	logic i_lval;
	logic i_interrupt_en;
	logic i_interrupt_pin;
	logic i_mono_sel;
	aoi_pkg::pix_beat_t i_pix;
	aoi_pkg::test_img_e i_test_image_sel;
	aoi_pkg::win_cfg_t  i_win_cfg;
	logic o_fval;
	logic o_lval;
	logic o_interrupt_en;
	aoi_pkg::pix_beat_t o_pix;
	logic [aoi_pkg::WB_OFFSET_WIDTH-1:0] o_wb_offset_width;
	logic [aoi_pkg::WB_OFFSET_WIDTH-1:0] o_wb_offset_height;

	int cyc;
	int err_cnt;
	logic exp_int;
	logic [31:0] lfsr_state;
	// inputs recorded by the cycle they were driven in
	logic rec_fval   [0:TIMEOUT_CYC+3];
	logic rec_lval   [0:TIMEOUT_CYC+3];
	logic rec_int_en [0:TIMEOUT_CYC+3];
	logic rec_pin    [0:TIMEOUT_CYC+3];
	logic rec_mono   [0:TIMEOUT_CYC+3];
	aoi_pkg::pix_beat_t rec_pix [0:TIMEOUT_CYC+3];
	aoi_pkg::test_img_e rec_img [0:TIMEOUT_CYC+3];
	aoi_pkg::win_cfg_t  rec_cfg [0:TIMEOUT_CYC+3];

	tb_clk_gen tb_clk_gen_i (
		.clk     (clk),
		.o_rst_n (rst_n)
	);

	wb_aoi_sel wb_aoi_sel_i (
		.clk                (clk),
		.i_rst_n            (rst_n),
		.i_fval             (i_fval),
		.i_lval             (i_lval),
		.i_pix              (i_pix),
		.i_interrupt_en     (i_interrupt_en),
		.i_interrupt_pin    (i_interrupt_pin),
		.i_mono_sel         (i_mono_sel),
		.i_test_image_sel   (i_test_image_sel),
		.i_win_cfg          (i_win_cfg),
		.o_fval             (o_fval),
		.o_lval             (o_lval),
		.o_pix              (o_pix),
		.o_interrupt_en     (o_interrupt_en),
		.o_wb_offset_width  (o_wb_offset_width),
		.o_wb_offset_height (o_wb_offset_height)
	);

	// ----------------------------------------------------------
	// random bits
	// ----------------------------------------------------------
	// galois form of x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
	endfunction

	// one step per bit
	function automatic logic [63:0] take_bits(input int n);
		logic [63:0] v;
		int i;
		v = '0;
		for (i = 0; i < n; i++) begin
			v = {v[62:0], lfsr_state[0]};
			lfsr_state = lfsr_next(lfsr_state);
		end
		return v;
	endfunction

	// ----------------------------------------------------------
	// reference model
	// ----------------------------------------------------------
	// internal interrupt enable after the edge that takes cycle i
	function automatic logic int_en_state(input int i);
		int k;
		for (k = i; k >= 1; k--) begin
			if (!rec_int_en[k])
				return 1'b0;
			if (rec_fval[k] && !rec_fval[k-1])
				return 1'b1;
		end
		return 1'b0;
	endfunction

	// window enable while cycle t is on the inputs
	function automatic logic aoi_en(input int t);
		if (t < 1)
			return 1'b0;
		return int_en_state(t - 1) && !rec_mono[t] &&
			(rec_img[t] == aoi_pkg::TEST_IMG_REAL);
	endfunction

	// beat of cycle j inside the window captured at its frame start
	function automatic logic in_window(input int j);
		int g;
		int l;
		int s;
		aoi_pkg::win_cfg_t w;
		if (!rec_lval[j] || !aoi_en(j))
			return 1'b0;
		g = 0;
		while (j - g > 0 && rec_lval[j-g-1])
			g++;
		// walk back to the frame start counting line ends
		s = j;
		l = 0;
		while (s > 0 && !(rec_fval[s] && !rec_fval[s-1])) begin
			if (rec_lval[s-1] && !rec_lval[s])
				l++;
			s--;
		end
		if (s == 0)
			return 1'b0;
		w = rec_cfg[s];
		return g >= w.x_start / aoi_pkg::CHANNEL_NUM &&
			g < w.x_start / aoi_pkg::CHANNEL_NUM + w.width / aoi_pkg::CHANNEL_NUM &&
			l >= w.y_start && l < w.y_start + w.height;
	endfunction

	// data always passes and flags only in the window
	function automatic aoi_pkg::pix_beat_t exp_beat(input int j);
		aoi_pkg::pix_beat_t b;
		logic [aoi_pkg::CHANNEL_NUM-1:0] m;
		b = rec_pix[j];
		m = {aoi_pkg::CHANNEL_NUM{in_window(j)}};
		b.r_flag = b.r_flag & m;
		b.g_flag = b.g_flag & m;
		b.b_flag = b.b_flag & m;
		return b;
	endfunction

	// width and height seen after edge k or zero before any pin rise
	function automatic logic [23:0] exp_readback(input int k);
		int t;
		int s;
		aoi_pkg::win_cfg_t w;
		t = k - 1;
		while (t >= 1 && !(rec_pin[t] && !rec_pin[t-1]))
			t--;
		if (t < 1)
			return '0;
		s = t - 1;
		while (s >= 1 && !(rec_fval[s] && !rec_fval[s-1]))
			s--;
		if (s < 1)
			return '0;
		w = rec_cfg[s];
		return {w.width[11:2], 2'b00, w.height};
	endfunction

	// ----------------------------------------------------------
	// compare tasks
	// ----------------------------------------------------------
	task automatic stop_run();
		err_cnt++;
		$display("Checks failed");
		$fatal(1, "run stopped");
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("ERR %0t %s expected %b got %b", $time, name, exp, act);
			stop_run();
		end
	endtask

	task automatic check_beat(input string name, input aoi_pkg::pix_beat_t exp,
		input aoi_pkg::pix_beat_t act);
		if (act !== exp) begin
			$display("ERR %0t %s expected %h got %h", $time, name, exp, act);
			stop_run();
		end
	endtask

	task automatic check_word(input string name,
		input logic [aoi_pkg::WB_OFFSET_WIDTH-1:0] exp,
		input logic [aoi_pkg::WB_OFFSET_WIDTH-1:0] act);
		if (act !== exp) begin
			$display("ERR %0t %s expected %h got %h", $time, name, exp, act);
			stop_run();
		end
	endtask

	task automatic record_inputs(input int k);
		rec_fval[k]   = i_fval;
		rec_lval[k]   = i_lval;
		rec_int_en[k] = i_interrupt_en;
		rec_pin[k]    = i_interrupt_pin;
		rec_mono[k]   = i_mono_sel;
		rec_pix[k]    = i_pix;
		rec_img[k]    = i_test_image_sel;
		rec_cfg[k]    = i_win_cfg;
	endtask

	// ----------------------------------------------------------
	// compare process with outputs settled at the falling edge
	// ----------------------------------------------------------
	always @(posedge clk)
		cyc <= cyc + 1;

	always @(negedge clk) begin
		logic [23:0] rb;
		aoi_pkg::pix_beat_t flags_only;
		record_inputs(cyc);
		// interrupt level rises 3 clocks after fval falls and drops after enable
		if (cyc >= 1) begin
			if (!aoi_en(cyc - 1))
				exp_int = 1'b0;
			else if (cyc >= 4 && rec_fval[cyc-4] && !rec_fval[cyc-3])
				exp_int = 1'b1;
		end
		if (cyc >= 1 && !rst_n) begin
			// reset values of levels, flags and readback
			flags_only      = o_pix;
			flags_only.data = '0;
			check_bit("o_fval", 1'b0, o_fval);
			check_bit("o_lval", 1'b0, o_lval);
			check_beat("o_pix", '0, flags_only);
			check_bit("o_interrupt_en", 1'b0, o_interrupt_en);
			check_word("o_wb_offset_width", '0, o_wb_offset_width);
			check_word("o_wb_offset_height", '0, o_wb_offset_height);
		end else if (cyc >= 2) begin
			rb = exp_readback(cyc);
			check_bit("o_fval", rec_fval[cyc-2], o_fval);
			check_bit("o_lval", in_window(cyc - 2), o_lval);
			check_beat("o_pix", exp_beat(cyc - 2), o_pix);
			check_bit("o_interrupt_en", exp_int, o_interrupt_en);
			check_word("o_wb_offset_width", rb[23:12], o_wb_offset_width);
			check_word("o_wb_offset_height", rb[11:0], o_wb_offset_height);
		end
	end

	always @(posedge clk) begin
		if (cyc >= TIMEOUT_CYC) begin
			$display("timeout: stimulus still running after %0d cycles", TIMEOUT_CYC);
			stop_run();
		end
	end

	// ----------------------------------------------------------
	// stimulus
	// ----------------------------------------------------------
	task automatic next_cycle();
		@(posedge clk);
		#(DRV_DLY);
	endtask

	task automatic drive_pix();
		logic [63:0] bits;
		bits = take_bits(52);
		i_pix = bits[51:0];
	endtask

	// window inside the 16 groups and 6 lines and never empty
	task automatic new_window();
		int xs;
		int ys;
		int wg;
		xs = take_bits(4) % 12;
		ys = take_bits(3) % 5;
		i_win_cfg.x_start = xs * 4 + take_bits(2);
		wg = 1 + take_bits(4) % (16 - xs);
		i_win_cfg.width   = wg * 4 + take_bits(2);
		i_win_cfg.y_start = ys;
		i_win_cfg.height  = 1 + take_bits(3) % (6 - ys);
	endtask

	// frames 2, 4 and 5 run with the window off
	task automatic set_frame_ctrl(input int f);
		i_mono_sel       = (f == 4);
		i_interrupt_en   = (f != 2);
		i_test_image_sel = (f == 5) ? aoi_pkg::TEST_IMG_DIAG_STILL : aoi_pkg::TEST_IMG_REAL;
	endtask

	task automatic run_frame(input int f);
		int ln;
		int bt;
		next_cycle();
		set_frame_ctrl(f);
		new_window();
		drive_pix();
		next_cycle();
		i_fval = 1'b1;
		drive_pix();
		repeat (GAP_CYC) begin
			next_cycle();
			drive_pix();
		end
		for (ln = 0; ln < LINES; ln++) begin
			for (bt = 0; bt < BEATS; bt++) begin
				next_cycle();
				i_lval = 1'b1;
				// mid-frame window change and late interrupt enable
				if (ln == MID_LINE && bt == 0 && f == 1)
					new_window();
				if (ln == MID_LINE && bt == 0 && f == 2)
					i_interrupt_en = 1'b1;
				drive_pix();
			end
			repeat (GAP_CYC) begin
				next_cycle();
				i_lval = 1'b0;
				drive_pix();
			end
		end
		next_cycle();
		i_fval = 1'b0;
		drive_pix();
		// pin pulse once the interrupt level is up
		for (bt = 0; bt < END_GAP; bt++) begin
			next_cycle();
			i_interrupt_pin = (bt >= 3 && bt < 5);
			drive_pix();
		end
	endtask

	initial begin
		int f;
		cyc              = 0;
		err_cnt          = 0;
		exp_int          = 1'b0;
		lfsr_state       = LFSR_SEED;
		i_fval           = 1'b0;
		i_lval           = 1'b0;
		i_pix            = '0;
		i_interrupt_en   = 1'b0;
		i_interrupt_pin  = 1'b0;
		i_mono_sel       = 1'b0;
		i_test_image_sel = aoi_pkg::TEST_IMG_REAL;
		i_win_cfg        = '0;
		record_inputs(0);
		@(posedge rst_n);
		for (f = 0; f < FRAMES; f++)
			run_frame(f);
		repeat (TAIL_CYC) next_cycle();
		if (err_cnt == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

// ==== testbench/tb_clk_gen.sv ====
`timescale 1ns/100ps

module tb_clk_gen (
	output logic clk,
	output logic o_rst_n
);

	// 40 ns period
	localparam real HALF_PERIOD = 20.0;
	localparam int  RST_CYCLES  = 8;

	initial begin
		clk = 1'b0;
		forever #(HALF_PERIOD) clk = ~clk;
	end

	// release a little after the last reset edge
	initial begin
		o_rst_n = 1'b0;
		repeat (RST_CYCLES) @(posedge clk);
		#2 o_rst_n = 1'b1;
	end

endmodule

// ==== hdl/wb_aoi_sel.sv ====
`timescale 1ns/100ps

module wb_aoi_sel (
	input  logic                                clk,
	input  logic                                i_rst_n,
	input  logic                                i_fval,
	input  logic                                i_lval,
	input  aoi_pkg::pix_beat_t                  i_pix,
	input  logic                                i_interrupt_en,
	input  logic                                i_interrupt_pin,
	input  logic                                i_mono_sel,
	input  aoi_pkg::test_img_e                  i_test_image_sel,
	input  aoi_pkg::win_cfg_t                   i_win_cfg,
	output logic                                o_fval,
	output logic                                o_lval,
	output aoi_pkg::pix_beat_t                  o_pix,
	output logic                                o_interrupt_en,
	output logic [aoi_pkg::WB_OFFSET_WIDTH-1:0] o_wb_offset_width,
	output logic [aoi_pkg::WB_OFFSET_WIDTH-1:0] o_wb_offset_height
);

	// input side to the rest
	logic              aoi_enable;
	logic              fval_dly;
	logic              fval_fall;
	aoi_pkg::win_reg_t win;
	// window mark to the output side
	logic              in_window;

	// ----------------------------------------------------------
	// frame edges, window capture, enable
	// ----------------------------------------------------------
	aoi_frame_ctrl aoi_frame_ctrl_i (
		.clk              (clk),
		.i_rst_n          (i_rst_n),
		.i_fval           (i_fval),
		.i_interrupt_en   (i_interrupt_en),
		.i_mono_sel       (i_mono_sel),
		.i_test_image_sel (i_test_image_sel),
		.i_win_cfg        (i_win_cfg),
		.o_aoi_enable     (aoi_enable),
		.o_fval_dly       (fval_dly),
		.o_fval_fall      (fval_fall),
		.o_win            (win)
	);

	// counters and x/y enables
	aoi_window_gen aoi_window_gen_i (
		.clk          (clk),
		.i_rst_n      (i_rst_n),
		.i_fval       (i_fval),
		.i_lval       (i_lval),
		.i_aoi_enable (aoi_enable),
		.i_fval_dly   (fval_dly),
		.i_win        (win),
		.o_in_window  (in_window)
	);

	// delayed stream, interrupt level, readback
	aoi_stat_out aoi_stat_out_i (
		.clk                (clk),
		.i_rst_n            (i_rst_n),
		.i_fval_dly         (fval_dly),
		.i_fval_fall        (fval_fall),
		.i_pix              (i_pix),
		.i_in_window        (in_window),
		.i_aoi_enable       (aoi_enable),
		.i_interrupt_pin    (i_interrupt_pin),
		.i_win              (win),
		.o_fval             (o_fval),
		.o_lval             (o_lval),
		.o_pix              (o_pix),
		.o_interrupt_en     (o_interrupt_en),
		.o_wb_offset_width  (o_wb_offset_width),
		.o_wb_offset_height (o_wb_offset_height)
	);

endmodule

// ==== hdl/aoi_stat_out.sv ====
`timescale 1ns/100ps

module aoi_stat_out (
	input  logic                                clk,
	input  logic                                i_rst_n,
	input  logic                                i_fval_dly,
	input  logic                                i_fval_fall,
	input  aoi_pkg::pix_beat_t                  i_pix,
	input  logic                                i_in_window,
	input  logic                                i_aoi_enable,
	input  logic                                i_interrupt_pin,
	input  aoi_pkg::win_reg_t                   i_win,
	output logic                                o_fval,
	output logic                                o_lval,
	output aoi_pkg::pix_beat_t                  o_pix,
	output logic                                o_interrupt_en,
	output logic [aoi_pkg::WB_OFFSET_WIDTH-1:0] o_wb_offset_width,
	output logic [aoi_pkg::WB_OFFSET_WIDTH-1:0] o_wb_offset_height
);

	// beat pipeline, data and flags
	aoi_pkg::pix_beat_t                     pix_dly0;
	aoi_pkg::pix_beat_t                     pix_dly1;
	// window mark spread over all channels
	logic [aoi_pkg::CHANNEL_NUM-1:0]        win_mask;
	logic                                   int_reg;
	logic                                   int_pin_dly;
	logic                                   int_pin_rise;
	// readback copies, width still in groups
	logic [aoi_pkg::WB_OFFSET_WIDTH_RB-1:0] width_latch;
	logic [aoi_pkg::WB_OFFSET_WIDTH-1:0]    height_latch;

	// ----------------------------------------------------------
	// stream delay
	// ----------------------------------------------------------
	// fval comes in one clock late already
	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			o_fval <= 1'b0;
		end else begin
			o_fval <= i_fval_dly;
		end
	end

	// two stages of payload
	always_ff @(posedge clk) begin
		pix_dly0 <= i_pix;
		pix_dly1 <= pix_dly0;
	end

	// flags only inside the window, data always passes
	assign win_mask = {aoi_pkg::CHANNEL_NUM{i_in_window}};
	assign o_pix    = '{
		data:   pix_dly1.data,
		r_flag: pix_dly1.r_flag & win_mask,
		g_flag: pix_dly1.g_flag & win_mask,
		b_flag: pix_dly1.b_flag & win_mask
	};
	assign o_lval   = i_in_window;

	// ----------------------------------------------------------
	// interrupt level
	// ----------------------------------------------------------
	// set at frame end, cleared as soon as the window is off
	always_ff @(posedge clk) begin
		if (!i_rst_n || !i_aoi_enable) begin
			int_reg <= 1'b0;
		end else if (i_fval_fall) begin
			int_reg <= 1'b1;
		end
	end

	assign o_interrupt_en = int_reg;

	// ----------------------------------------------------------
	// readback
	// ----------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			int_pin_dly <= 1'b0;
		end else begin
			int_pin_dly <= i_interrupt_pin;
		end
	end

	assign int_pin_rise = i_interrupt_pin & ~int_pin_dly;

	// hold size of the window in use when the interrupt is taken
	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			width_latch  <= '0;
			height_latch <= '0;
		end else if (int_pin_rise) begin
			width_latch  <= i_win.width;
			height_latch <= i_win.height;
		end
	end

	// back to pixel units, dropped bits read as zero
	assign o_wb_offset_width  = {width_latch, {aoi_pkg::REDUCE_BIT{1'b0}}};
	assign o_wb_offset_height = height_latch;

endmodule

// ==== hdl/aoi_window_gen.sv ====
`timescale 1ns/100ps

module aoi_window_gen (
	input  logic              clk,
	input  logic              i_rst_n,
	input  logic              i_fval,
	input  logic              i_lval,
	input  logic              i_aoi_enable,
	input  logic              i_fval_dly,
	input  aoi_pkg::win_reg_t i_win,
	output logic              o_in_window
);

	// line-valid delay for the fall
	logic                                  lval_dly;
	logic                                  lval_fall;
	// beat index within the line, in groups
	logic [aoi_pkg::WB_OFFSET_WIDTH_RB-1:0] pix_cnt;
	// line index within the frame
	logic [aoi_pkg::WB_OFFSET_WIDTH-1:0]    line_cnt;
	// window ends
	logic [aoi_pkg::WB_OFFSET_WIDTH_RB-1:0] x_end;
	logic [aoi_pkg::WB_OFFSET_WIDTH-1:0]    y_end;
	logic                                  x_enable;
	logic                                  y_enable;

	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			lval_dly <= 1'b0;
		end else begin
			lval_dly <= i_lval;
		end
	end

	assign lval_fall = lval_dly & ~i_lval;

	assign x_end = i_win.x_start + i_win.width;
	assign y_end = i_win.y_start + i_win.height;

	// ----------------------------------------------------------
	// counters
	// ----------------------------------------------------------
	// held at zero with the window off or between frames
	always_ff @(posedge clk) begin
		if (!i_rst_n || !i_aoi_enable || !i_fval) begin
			line_cnt <= '0;
		end else if (lval_fall) begin
			line_cnt <= line_cnt + 1'b1;
		end
	end

	// cleared between lines, so it equals the beat index
	always_ff @(posedge clk) begin
		if (!i_rst_n || !i_aoi_enable || !i_fval || !i_lval) begin
			pix_cnt <= '0;
		end else begin
			pix_cnt <= pix_cnt + 1'b1;
		end
	end

	// ----------------------------------------------------------
	// x and y enables
	// ----------------------------------------------------------
	// delayed fval, since the window registers load on the rise
	// set at start count, cleared at start plus size
	always_ff @(posedge clk) begin
		if (!i_rst_n || !i_aoi_enable || !i_fval_dly || !i_lval) begin
			x_enable <= 1'b0;
		end else if (pix_cnt == i_win.x_start) begin
			x_enable <= 1'b1;
		end else if (pix_cnt == x_end) begin
			x_enable <= 1'b0;
		end
	end

	// line count settles in the idle gap before the next line
	always_ff @(posedge clk) begin
		if (!i_rst_n || !i_aoi_enable || !i_fval_dly) begin
			y_enable <= 1'b0;
		end else if (line_cnt == i_win.y_start) begin
			y_enable <= 1'b1;
		end else if (line_cnt == y_end) begin
			y_enable <= 1'b0;
		end
	end

	// window mark, two clocks behind the input beat
	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			o_in_window <= 1'b0;
		end else begin
			o_in_window <= x_enable & y_enable;
		end
	end

endmodule

// ==== hdl/aoi_frame_ctrl.sv ====
`timescale 1ns/100ps

module aoi_frame_ctrl (
	input  logic               clk,
	input  logic               i_rst_n,
	input  logic               i_fval,
	input  logic               i_interrupt_en,
	input  logic               i_mono_sel,
	input  aoi_pkg::test_img_e i_test_image_sel,
	input  aoi_pkg::win_cfg_t  i_win_cfg,
	output logic               o_aoi_enable,
	output logic               o_fval_dly,
	output logic               o_fval_fall,
	output aoi_pkg::win_reg_t  o_win
);

	// two-stage frame-valid delay
	logic fval_dly0;
	logic fval_dly1;
	// frame start, combinational on the input side
	logic fval_rise;
	// interrupt enable as taken at frame start
	logic interrupt_en_int;

	// ----------------------------------------------------------
	// frame edges
	// ----------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			fval_dly0 <= 1'b0;
			fval_dly1 <= 1'b0;
		end else begin
			fval_dly0 <= i_fval;
			fval_dly1 <= fval_dly0;
		end
	end

	// input high, first stage still low
	assign fval_rise  = i_fval & ~fval_dly0;
	assign o_fval_dly = fval_dly0;

	// end of frame seen on the delay chain, registered once more
	// so the strobe lands two clocks after the input falls
	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			o_fval_fall <= 1'b0;
		end else begin
			o_fval_fall <= fval_dly1 & ~fval_dly0;
		end
	end

	// ----------------------------------------------------------
	// interrupt enable
	// ----------------------------------------------------------
	// drops at once when firmware clears it
	// only picked up at a frame start, so a frame is never cut in half
	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			interrupt_en_int <= 1'b0;
		end else if (!i_interrupt_en) begin
			interrupt_en_int <= 1'b0;
		end else if (fval_rise) begin
			interrupt_en_int <= 1'b1;
		end
	end

	// colour mode, real image and interrupt enabled
	assign o_aoi_enable = interrupt_en_int && !i_mono_sel &&
		(i_test_image_sel == aoi_pkg::TEST_IMG_REAL);

	// ----------------------------------------------------------
	// window capture
	// ----------------------------------------------------------
	// x values cut to four-pixel groups
	// y values stay in lines
	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			o_win <= '0;
		end else if (fval_rise) begin
			o_win.x_start <= i_win_cfg.x_start[aoi_pkg::WB_OFFSET_WIDTH-1:aoi_pkg::REDUCE_BIT];
			o_win.width   <= i_win_cfg.width[aoi_pkg::WB_OFFSET_WIDTH-1:aoi_pkg::REDUCE_BIT];
			o_win.y_start <= i_win_cfg.y_start;
			o_win.height  <= i_win_cfg.height;
		end
	end

endmodule

// ==== hdl/aoi_pkg.sv ====
package aoi_pkg;

	// ----------------------------------------------------------
	// stream and window sizes
	// ----------------------------------------------------------
	// bits per pixel
	localparam int SENSOR_DAT_WIDTH   = 10;
	// pixels per clock
	localparam int CHANNEL_NUM        = 4;
	// firmware window registers, pixel units
	localparam int WB_OFFSET_WIDTH    = 12;
	// log2 of channel count, low x bits dropped for groups
	localparam int REDUCE_BIT         = 2;
	// x registers counted in four-pixel groups
	localparam int WB_OFFSET_WIDTH_RB = WB_OFFSET_WIDTH - REDUCE_BIT;
	// whole data bus of one beat
	localparam int PIX_BUS_WIDTH      = SENSOR_DAT_WIDTH * CHANNEL_NUM;

	// ----------------------------------------------------------
	// bundled types
	// ----------------------------------------------------------
	// one beat: pixel data plus per-pixel colour flags
	typedef struct packed {
		logic [PIX_BUS_WIDTH-1:0] data;
		logic [CHANNEL_NUM-1:0]   r_flag;
		logic [CHANNEL_NUM-1:0]   g_flag;
		logic [CHANNEL_NUM-1:0]   b_flag;
	} pix_beat_t;

	// window as set by firmware, pixels and lines
	typedef struct packed {
		logic [WB_OFFSET_WIDTH-1:0] x_start;
		logic [WB_OFFSET_WIDTH-1:0] width;
		logic [WB_OFFSET_WIDTH-1:0] y_start;
		logic [WB_OFFSET_WIDTH-1:0] height;
	} win_cfg_t;

	// window as captured at frame start, x in groups
	typedef struct packed {
		logic [WB_OFFSET_WIDTH_RB-1:0] x_start;
		logic [WB_OFFSET_WIDTH_RB-1:0] width;
		logic [WB_OFFSET_WIDTH-1:0]    y_start;
		logic [WB_OFFSET_WIDTH-1:0]    height;
	} win_reg_t;

	// test image select code, only the real image enables the window
	typedef enum logic [2:0] {
		TEST_IMG_REAL       = 3'b000,
		TEST_IMG_GRAY_FRAME = 3'b001,
		TEST_IMG_DIAG_MOVE  = 3'b010,
		TEST_IMG_DIAG_STILL = 3'b110
	} test_img_e;

endpackage
